//--- hw/am_pkg.sv
`default_nettype none

package am_pkg;

    // Default geometry of the associative memory
    localparam int NUM_CLASSES = 26;
    localparam int SEG_COUNT   = 10;
    localparam int SEG_WIDTH   = 64;

    // Width of the correct and total prediction counters
    localparam int COUNT_WIDTH = 16;

    // Sequencer states for one query pass
    typedef enum logic [1:0] {
        S_IDLE,
        S_QUERY,
        S_INFER,
        S_TALLY
    } am_state_t;

endpackage

`default_nettype wire

//--- hw/assoc_mem_fsm.sv
`default_nettype none

module assoc_mem_fsm #(
    parameter int seg_count = am_pkg::SEG_COUNT,
    localparam int seg_w = (seg_count > 1) ? $clog2(seg_count) : 1
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             en,
    input  logic             start_querying,
    input  logic             testing_dataset_finished,
    output logic [seg_w-1:0] query_ctr,
    output logic             comparing_query_hv_with_class_hv,
    output logic             inferring_class,
    output logic             tallying_accuracy,
    output logic             clear_tally,
    output logic             busy
);

    am_pkg::am_state_t state;
    logic              querying_done;

    // The last segment only counts when en is still high on that cycle
    assign querying_done = en && (query_ctr == seg_w'(seg_count - 1));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= am_pkg::S_IDLE;
        end else begin
            case (state)
                am_pkg::S_IDLE: begin
                    if (start_querying && en) begin
                        state <= am_pkg::S_QUERY;
                    end
                end
                am_pkg::S_QUERY: begin
                    if (querying_done) begin
                        state <= am_pkg::S_INFER;
                    end
                end
                am_pkg::S_INFER: begin
                    state <= am_pkg::S_TALLY;
                end
                default: begin
                    // Next query follows directly unless the dataset is done
                    if (testing_dataset_finished) begin
                        state <= am_pkg::S_IDLE;
                    end else begin
                        state <= am_pkg::S_QUERY;
                    end
                end
            endcase
        end
    end

    assign comparing_query_hv_with_class_hv = (state == am_pkg::S_QUERY);
    assign inferring_class                  = (state == am_pkg::S_INFER);
    assign tallying_accuracy                = (state == am_pkg::S_TALLY);
    assign busy                             = (state != am_pkg::S_IDLE);

    // Counters are cleared on the same cycle that accepts a new run
    assign clear_tally = (state == am_pkg::S_IDLE) && start_querying && en;

    // The segment index is held at zero whenever the query is paused or not running
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            query_ctr <= '0;
        end else if ((state == am_pkg::S_QUERY) && en && !querying_done) begin
            query_ctr <= query_ctr + 1'b1;
        end else begin
            query_ctr <= '0;
        end
    end

    a_strobes_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({comparing_query_hv_with_class_hv, inferring_class,
                  tallying_accuracy, clear_tally}));

    a_ctr_idle: assert property (@(posedge clk) disable iff (!nrst)
        (state != am_pkg::S_QUERY) |-> (query_ctr == '0));

endmodule

`default_nettype wire

//--- hw/class_hv_mem.sv
`default_nettype none

module class_hv_mem #(
    parameter int num_classes = am_pkg::NUM_CLASSES,
    parameter int seg_count   = am_pkg::SEG_COUNT,
    parameter int seg_width   = am_pkg::SEG_WIDTH,
    localparam int cls_w = (num_classes > 1) ? $clog2(num_classes) : 1,
    localparam int seg_w = (seg_count > 1) ? $clog2(seg_count) : 1
) (
    input  logic                                  clk,
    input  logic                                  nrst,
    input  logic                                  wr_en,
    input  logic [cls_w-1:0]                      wr_class,
    input  logic [seg_w-1:0]                      wr_seg,
    input  logic [seg_width-1:0]                  wr_data,
    input  logic                                  busy,
    input  logic [seg_w-1:0]                      rd_seg,
    output logic [num_classes-1:0][seg_width-1:0] class_seg_bus
);

    logic [seg_width-1:0] mem [num_classes][seg_count];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_class][wr_seg] <= wr_data;
        end
    end

    // Every class presents the same segment so all distances form in parallel
    always_comb begin
        for (int c = 0; c < num_classes; c++) begin
            class_seg_bus[c] = mem[c][rd_seg];
        end
    end

    // Loading is only allowed between runs, never while queries are compared
    a_no_write_busy: assert property (@(posedge clk) disable iff (!nrst)
        !(wr_en && busy));

endmodule

`default_nettype wire

//--- hw/segment_distance.sv
`default_nettype none

module segment_distance #(
    parameter int num_classes = am_pkg::NUM_CLASSES,
    parameter int seg_count   = am_pkg::SEG_COUNT,
    parameter int seg_width   = am_pkg::SEG_WIDTH,
    localparam int seg_w  = (seg_count > 1) ? $clog2(seg_count) : 1,
    localparam int dist_w = $clog2(seg_count * seg_width + 1),
    localparam int pop_w  = $clog2(seg_width + 1)
) (
    input  logic                                  clk,
    input  logic                                  nrst,
    input  logic                                  accumulate,
    input  logic [seg_w-1:0]                      seg_idx,
    input  logic [seg_width-1:0]                  query_seg,
    input  logic [num_classes-1:0][seg_width-1:0] class_seg_bus,
    output logic [num_classes-1:0][dist_w-1:0]    dist_bus
);

    logic [pop_w-1:0]  seg_pop [num_classes];
    logic [dist_w-1:0] acc     [num_classes];

    // Hamming distance of the current segment for each class
    always_comb begin
        logic [seg_width-1:0] diff;
        for (int c = 0; c < num_classes; c++) begin
            diff = query_seg ^ class_seg_bus[c];
            seg_pop[c] = '0;
            for (int b = 0; b < seg_width; b++) begin
                seg_pop[c] = seg_pop[c] + pop_w'(diff[b]);
            end
        end
    end

    // Segment 0 starts a fresh sum, so a restarted query needs no separate clear
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int c = 0; c < num_classes; c++) begin
                acc[c] <= '0;
            end
        end else if (accumulate) begin
            for (int c = 0; c < num_classes; c++) begin
                if (seg_idx == '0) begin
                    acc[c] <= dist_w'(seg_pop[c]);
                end else begin
                    acc[c] <= acc[c] + dist_w'(seg_pop[c]);
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < num_classes; c++) begin
            dist_bus[c] = acc[c];
        end
    end

endmodule

`default_nettype wire

//--- hw/class_argmin.sv
`default_nettype none

module class_argmin #(
    parameter int num_classes = am_pkg::NUM_CLASSES,
    parameter int seg_count   = am_pkg::SEG_COUNT,
    parameter int seg_width   = am_pkg::SEG_WIDTH,
    localparam int cls_w  = (num_classes > 1) ? $clog2(num_classes) : 1,
    localparam int dist_w = $clog2(seg_count * seg_width + 1)
) (
    input  logic                               clk,
    input  logic                               nrst,
    input  logic                               infer,
    input  logic [num_classes-1:0][dist_w-1:0] dist_bus,
    output logic [cls_w-1:0]                   predicted_class
);

    logic [dist_w-1:0] best_dist;
    logic [cls_w-1:0]  best_idx;

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        best_dist = dist_bus[0];
        best_idx  = '0;
        for (int c = 1; c < num_classes; c++) begin
            if (dist_bus[c] < best_dist) begin
                best_dist = dist_bus[c];
                best_idx  = cls_w'(c);
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            predicted_class <= '0;
        end else if (infer) begin
            predicted_class <= best_idx;
        end
    end

endmodule

`default_nettype wire

//--- hw/accuracy_tally.sv
`default_nettype none

module accuracy_tally #(
    parameter int num_classes = am_pkg::NUM_CLASSES,
    localparam int cls_w = (num_classes > 1) ? $clog2(num_classes) : 1
) (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           clear,
    input  logic                           tally,
    input  logic [cls_w-1:0]               predicted_class,
    input  logic [cls_w-1:0]               query_label,
    output logic [am_pkg::COUNT_WIDTH-1:0] correct_count,
    output logic [am_pkg::COUNT_WIDTH-1:0] total_count
);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            correct_count <= '0;
            total_count   <= '0;
        end else if (clear) begin
            correct_count <= '0;
            total_count   <= '0;
        end else if (tally) begin
            total_count <= total_count + 1'b1;
            if (predicted_class == query_label) begin
                correct_count <= correct_count + 1'b1;
            end
        end
    end

    a_correct_le_total: assert property (@(posedge clk) disable iff (!nrst)
        correct_count <= total_count);

endmodule

`default_nettype wire

//--- hw/assoc_mem_top.sv
`default_nettype none

module assoc_mem_top #(
    parameter int num_classes = am_pkg::NUM_CLASSES,
    parameter int seg_count   = am_pkg::SEG_COUNT,
    parameter int seg_width   = am_pkg::SEG_WIDTH,
    localparam int cls_w  = (num_classes > 1) ? $clog2(num_classes) : 1,
    localparam int seg_w  = (seg_count > 1) ? $clog2(seg_count) : 1,
    localparam int dist_w = $clog2(seg_count * seg_width + 1)
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             en,
    input  logic                             start_querying,
    input  logic                             testing_dataset_finished,
    input  logic [seg_count*seg_width-1:0]   query_hv,
    input  logic [cls_w-1:0]                 query_label,
    input  logic                             class_wr_en,
    input  logic [cls_w-1:0]                 class_wr_class,
    input  logic [seg_w-1:0]                 class_wr_seg,
    input  logic [seg_width-1:0]             class_wr_data,
    output logic                             busy,
    output logic [cls_w-1:0]                 predicted_class,
    output logic                             prediction_valid,
    output logic [am_pkg::COUNT_WIDTH-1:0]   correct_count,
    output logic [am_pkg::COUNT_WIDTH-1:0]   total_count
);

    logic [seg_w-1:0]                      query_ctr;
    logic                                  comparing_query_hv_with_class_hv;
    logic                                  inferring_class;
    logic                                  tallying_accuracy;
    logic                                  clear_tally;
    logic [seg_width-1:0]                  query_seg;
    logic [num_classes-1:0][seg_width-1:0] class_seg_bus;
    logic [num_classes-1:0][dist_w-1:0]    dist_bus;

    assign query_seg        = query_hv[query_ctr*seg_width +: seg_width];
    assign prediction_valid = tallying_accuracy;

    assoc_mem_fsm #(.seg_count(seg_count)) u_fsm (
        .clk                              (clk),
        .nrst                             (nrst),
        .en                               (en),
        .start_querying                   (start_querying),
        .testing_dataset_finished         (testing_dataset_finished),
        .query_ctr                        (query_ctr),
        .comparing_query_hv_with_class_hv (comparing_query_hv_with_class_hv),
        .inferring_class                  (inferring_class),
        .tallying_accuracy                (tallying_accuracy),
        .clear_tally                      (clear_tally),
        .busy                             (busy)
    );

    class_hv_mem #(
        .num_classes (num_classes),
        .seg_count   (seg_count),
        .seg_width   (seg_width)
    ) u_mem (
        .clk           (clk),
        .nrst          (nrst),
        .wr_en         (class_wr_en),
        .wr_class      (class_wr_class),
        .wr_seg        (class_wr_seg),
        .wr_data       (class_wr_data),
        .busy          (busy),
        .rd_seg        (query_ctr),
        .class_seg_bus (class_seg_bus)
    );

    // A paused query must not add a segment, so en also gates accumulation
    segment_distance #(
        .num_classes (num_classes),
        .seg_count   (seg_count),
        .seg_width   (seg_width)
    ) u_dist (
        .clk           (clk),
        .nrst          (nrst),
        .accumulate    (comparing_query_hv_with_class_hv && en),
        .seg_idx       (query_ctr),
        .query_seg     (query_seg),
        .class_seg_bus (class_seg_bus),
        .dist_bus      (dist_bus)
    );

    class_argmin #(
        .num_classes (num_classes),
        .seg_count   (seg_count),
        .seg_width   (seg_width)
    ) u_argmin (
        .clk             (clk),
        .nrst            (nrst),
        .infer           (inferring_class),
        .dist_bus        (dist_bus),
        .predicted_class (predicted_class)
    );

    accuracy_tally #(.num_classes(num_classes)) u_tally (
        .clk             (clk),
        .nrst            (nrst),
        .clear           (clear_tally),
        .tally           (tallying_accuracy),
        .predicted_class (predicted_class),
        .query_label     (query_label),
        .correct_count   (correct_count),
        .total_count     (total_count)
    );

endmodule

`default_nettype wire

//--- verif/tb_assoc_mem.sv
`default_nettype none

module tb_assoc_mem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_classes  = am_pkg::NUM_CLASSES;
    localparam int seg_count    = am_pkg::SEG_COUNT;
    localparam int seg_width    = am_pkg::SEG_WIDTH;
    localparam int cnt_w        = am_pkg::COUNT_WIDTH;
    localparam int hv_w         = seg_count * seg_width;
    localparam int cls_w        = (num_classes > 1) ? $clog2(num_classes) : 1;
    localparam int seg_w        = (seg_count > 1) ? $clog2(seg_count) : 1;
    localparam int pos_w        = $clog2(hv_w);
    localparam int reset_cycles = 8;
    localparam int stream_len   = 8;
    localparam int pause_cycles = 5;
    localparam int tie_low      = 5;
    localparam int tie_high     = 19;
    // Single-query tests plus the stream, one full class load and one class reload
    localparam int num_queries  = stream_len + 4;
    localparam int load_cycles  = (num_classes + 1) * (seg_count + 1);
    localparam int cycle_limit  = reset_cycles + load_cycles
                                + num_queries * (seg_count + 2) + pause_cycles + 100;

    logic                 clk;
    logic                 nrst;
    logic                 en;
    logic                 start_querying;
    logic                 testing_dataset_finished;
    logic [hv_w-1:0]      query_hv;
    logic [cls_w-1:0]     query_label;
    logic                 class_wr_en;
    logic [cls_w-1:0]     class_wr_class;
    logic [seg_w-1:0]     class_wr_seg;
    logic [seg_width-1:0] class_wr_data;
    logic                 busy;
    logic [cls_w-1:0]     predicted_class;
    logic                 prediction_valid;
    logic [cnt_w-1:0]     correct_count;
    logic [cnt_w-1:0]     total_count;

    logic [31:0]     lfsr_state;
    logic [hv_w-1:0] class_model [num_classes];
    int              error_count;
    int              check_count;
    int              cycle_count;

    assoc_mem_top #(
        .num_classes (num_classes),
        .seg_count   (seg_count),
        .seg_width   (seg_width)
    ) UUT (
        .clk                      (clk),
        .nrst                     (nrst),
        .en                       (en),
        .start_querying           (start_querying),
        .testing_dataset_finished (testing_dataset_finished),
        .query_hv                 (query_hv),
        .query_label              (query_label),
        .class_wr_en              (class_wr_en),
        .class_wr_class           (class_wr_class),
        .class_wr_seg             (class_wr_seg),
        .class_wr_data            (class_wr_data),
        .busy                     (busy),
        .predicted_class          (predicted_class),
        .prediction_valid         (prediction_valid),
        .correct_count            (correct_count),
        .total_count              (total_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no result from the DUT after %0d cycles", cycle_count);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Something failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_bit());
        end
        return r;
    endfunction

    function automatic logic [hv_w-1:0] rand_hv();
        logic [hv_w-1:0] v;
        for (int i = 0; i < hv_w; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    function automatic logic [hv_w-1:0] flip_bits(input logic [hv_w-1:0] hv, input int n);
        logic [hv_w-1:0] v;
        int              pos;
        v = hv;
        for (int i = 0; i < n; i++) begin
            pos = rand_bits(pos_w) % hv_w;
            v[pos] = ~v[pos];
        end
        return v;
    endfunction

    function automatic int hamming(input logic [hv_w-1:0] a, input logic [hv_w-1:0] b);
        int d;
        d = 0;
        for (int i = 0; i < hv_w; i++) begin
            d = d + ((a[i] != b[i]) ? 1 : 0);
        end
        return d;
    endfunction

    // Nearest class in the model where the lowest index wins a tie
    function automatic int model_argmin(input logic [hv_w-1:0] hv);
        int best;
        int best_d;
        int d;
        best   = 0;
        best_d = hamming(hv, class_model[0]);
        for (int c = 1; c < num_classes; c++) begin
            d = hamming(hv, class_model[c]);
            if (d < best_d) begin
                best   = c;
                best_d = d;
            end
        end
        return best;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic load_class(input int c, input logic [hv_w-1:0] hv);
        for (int s = 0; s < seg_count; s++) begin
            @(posedge clk);
            class_wr_en    <= 1'b1;
            class_wr_class <= cls_w'(c);
            class_wr_seg   <= seg_w'(s);
            class_wr_data  <= hv[s*seg_width +: seg_width];
        end
        @(posedge clk);
        class_wr_en <= 1'b0;
        class_model[c] = hv;
    endtask

    // The first query of a run raises start and later ones follow the tally edge
    task automatic issue_query(input logic [hv_w-1:0] hv, input int label,
                               input logic last, input logic first);
        @(posedge clk);
        query_hv                 <= hv;
        query_label              <= cls_w'(label);
        testing_dataset_finished <= last;
        start_querying           <= first;
        if (first) begin
            @(posedge clk);
            start_querying <= 1'b0;
        end
    endtask

    task automatic collect_prediction(input string name, input int expected);
        @(negedge clk);
        while (!prediction_valid) begin
            @(negedge clk);
        end
        check(name, 32'(expected), 32'(predicted_class));
    endtask

    task automatic check_run_end(input string name, input int correct, input int total);
        @(negedge clk);
        check({name, "_busy"}, 32'd0, 32'(busy));
        check({name, "_valid"}, 32'd0, 32'(prediction_valid));
        check({name, "_correct"}, 32'(correct), 32'(correct_count));
        check({name, "_total"}, 32'(total), 32'(total_count));
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        check("reset_busy", 32'd0, 32'(busy));
        check("reset_valid", 32'd0, 32'(prediction_valid));
        check("reset_correct", 32'd0, 32'(correct_count));
        check("reset_total", 32'd0, 32'(total_count));
        // en is still low, so start must be ignored
        @(posedge clk);
        start_querying <= 1'b1;
        repeat (3) @(posedge clk);
        start_querying <= 1'b0;
        @(negedge clk);
        check("start_en_low_busy", 32'd0, 32'(busy));
        @(posedge clk);
        en <= 1'b1;
    endtask

    task automatic exact_match_query();
        issue_query(class_model[13], 13, 1'b1, 1'b1);
        collect_prediction("exact_match", 13);
        check_run_end("exact_match", 1, 1);
    endtask

    task automatic noisy_query_stream();
        logic [hv_w-1:0] hv;
        int              src;
        int              exp_class;
        int              exp_correct;
        exp_correct = 0;
        for (int i = 0; i < stream_len; i++) begin
            src       = rand_bits(cls_w) % num_classes;
            hv        = flip_bits(class_model[src], 6);
            exp_class = model_argmin(hv);
            if (exp_class == src) begin
                exp_correct++;
            end
            issue_query(hv, src, i == stream_len - 1, i == 0);
            collect_prediction("stream", exp_class);
        end
        check_run_end("stream", exp_correct, stream_len);
    endtask

    task automatic mislabeled_query();
        logic [hv_w-1:0] hv;
        int              exp_class;
        hv        = flip_bits(class_model[7], 3);
        exp_class = model_argmin(hv);
        issue_query(hv, (exp_class + 1) % num_classes, 1'b1, 1'b1);
        collect_prediction("wrong_label", exp_class);
        check_run_end("wrong_label", 0, 1);
    endtask

    // Two classes lie 8 bits apart and the query sits 4 bits from each
    task automatic equidistant_query();
        logic [hv_w-1:0] hv;
        int              pos0;
        pos0 = rand_bits(pos_w) % (hv_w - 8);
        hv   = class_model[tie_high];
        for (int i = 0; i < 8; i++) begin
            hv[pos0 + i] = ~hv[pos0 + i];
        end
        load_class(tie_low, hv);
        hv = class_model[tie_high];
        for (int i = 0; i < 4; i++) begin
            hv[pos0 + i] = ~hv[pos0 + i];
        end
        issue_query(hv, tie_low, 1'b1, 1'b1);
        collect_prediction("tie", tie_low);
        check_run_end("tie", 1, 1);
    endtask

    task automatic en_pause_query();
        logic [hv_w-1:0] hv;
        int              exp_class;
        int              start_cycle;
        hv        = flip_bits(class_model[11], 5);
        exp_class = model_argmin(hv);
        issue_query(hv, 11, 1'b1, 1'b1);
        @(negedge clk);
        start_cycle = cycle_count;
        repeat (3) @(posedge clk);
        en <= 1'b0;
        repeat (pause_cycles) @(posedge clk);
        en <= 1'b1;
        collect_prediction("en_pause", exp_class);
        check("en_pause_late", 32'd1, 32'(cycle_count - start_cycle > seg_count + 1));
        check_run_end("en_pause", (exp_class == 11) ? 1 : 0, 1);
    endtask

    initial begin
        clk                      = 1'b0;
        nrst                     = 1'b0;
        en                       = 1'b0;
        start_querying           = 1'b0;
        testing_dataset_finished = 1'b0;
        query_hv                 = '0;
        query_label              = '0;
        class_wr_en              = 1'b0;
        class_wr_class           = '0;
        class_wr_seg             = '0;
        class_wr_data            = '0;
        lfsr_state               = 32'h7d07;
        error_count              = 0;
        check_count              = 0;
        cycle_count              = 0;

        repeat (reset_cycles) @(posedge clk);
        nrst <= 1'b1;

        idle_after_reset();
        for (int c = 0; c < num_classes; c++) begin
            load_class(c, rand_hv());
        end
        exact_match_query();
        noisy_query_stream();
        mislabeled_query();
        equidistant_query();
        en_pause_query();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/am_pkg.sv
hw/assoc_mem_fsm.sv
hw/class_hv_mem.sv
hw/segment_distance.sv
hw/class_argmin.sv
hw/accuracy_tally.sv
hw/assoc_mem_top.sv
verif/tb_assoc_mem.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and reports pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_assoc_mem -o tb_assoc_mem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_assoc_mem > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0
